// ==== include/neo_video_params.svh ====
`ifndef NEO_VIDEO_PARAMS_SVH
`define NEO_VIDEO_PARAMS_SVH

// Raster geometry in dots and lines
`define H_TOTAL        384
`define H_VISIBLE      320
`define H_SYNC_START   336
`define H_SYNC_END     368
`define V_TOTAL        264
`define V_VISIBLE      224
`define V_SYNC_START   240
`define V_SYNC_END     243

// Fix layer, 8x8 tiles
`define MAP_COLS       40
`define MAP_ROWS       28
`define FIX_TILES      4

// Palette geometry
`define PAL_ENTRIES    256
`define BACKDROP_INDEX 255

// Position to RGB latency
`define PIPE_DELAY     4

// CPU word addresses
`define ADDR_PALETTE    16'h0000
`define ADDR_FIXMAP     16'h1000
`define ADDR_REG_SHADOW 16'h2000
`define ADDR_REG_BANK   16'h2001

`endif

// ==== src/neo_video_pkg.sv ====
`default_nettype none

package neo_video_pkg;

	// Target of one CPU access
	typedef enum logic [1:0]
	{
		REGION_PALETTE,
		REGION_FIXMAP,
		REGION_REG,
		REGION_NONE
	} busRegion_e;

	// Which control register inside the register region
	typedef enum logic
	{
		REG_SHADOW,
		REG_BANK
	} regSel_e;

	// One CPU access, strobes are single cycle
	typedef struct packed
	{
		logic [15:0] addr;
		logic [15:0] data;
		logic        wr;
		logic        rd;
	} busReq_t;

	// Raster position as it moves down the pixel pipeline
	typedef struct packed
	{
		logic [8:0] x;
		logic [8:0] y;
		logic       active;
		logic       nSync;
	} rasterPos_t;

	// Tile map write port
	typedef struct packed
	{
		logic [10:0] index;
		logic [15:0] data;
		logic        wr;
	} mapWrite_t;

	// Palette write port, index also used for CPU reads
	typedef struct packed
	{
		logic [7:0]  index;
		logic        bank;
		logic [15:0] data;
		logic        wr;
	} palWrite_t;

endpackage

`default_nettype wire

// ==== src/videoTiming.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_video_params.svh"

module videoTiming
(
	input  logic                    CLK_6MB,
	input  logic                    reset,
	output neo_video_pkg::rasterPos_t pos
);

	logic [8:0] xCount;
	logic [8:0] yCount;
	logic       lineEnd;
	logic       hSyncWin;
	logic       vSyncWin;

	assign lineEnd = (xCount == 9'(`H_TOTAL - 1));

	// Dot and line counters
	always_ff @(posedge CLK_6MB)
	begin
		if (reset)
		begin
			xCount <= '0;
			yCount <= '0;
		end
		else
		begin
			if (lineEnd)
			begin
				xCount <= '0;
				if (yCount == 9'(`V_TOTAL - 1))
					yCount <= '0;
				else
					yCount <= yCount + 9'd1;
			end
			else
			begin
				xCount <= xCount + 9'd1;
			end
		end
	end

	// Sync windows are half open, start included
	assign hSyncWin = (xCount >= 9'(`H_SYNC_START)) && (xCount < 9'(`H_SYNC_END));
	assign vSyncWin = (yCount >= 9'(`V_SYNC_START)) && (yCount < 9'(`V_SYNC_END));

	always_comb
	begin
		pos.x      = xCount;
		pos.y      = yCount;
		pos.active = (xCount < 9'(`H_VISIBLE)) && (yCount < 9'(`V_VISIBLE));
		// Composite sync, low in either window
		pos.nSync  = ~(hSyncWin | vSyncWin);
	end

endmodule

`default_nettype wire

// ==== src/cpuBusDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_video_params.svh"

module cpuBusDecode
(
	input  logic                     CLK_6MB,
	input  logic                     reset,
	input  neo_video_pkg::busReq_t   cpuReq,
	input  logic [15:0]              palReadData,
	input  logic [15:0]              mapReadData,
	output neo_video_pkg::palWrite_t palWr,
	output neo_video_pkg::mapWrite_t mapWr,
	output logic [15:0]              cpuDataOut,
	output logic                     palBank,
	output logic                     shadow
);

	neo_video_pkg::busRegion_e region;
	neo_video_pkg::busRegion_e prevRegion;
	neo_video_pkg::regSel_e    regSel;
	logic [15:0]               mapOffset;
	logic                      prevRead;
	logic [15:0]               regReadData;
	logic [15:0]               readMux;
	logic [15:0]               heldData;

	assign mapOffset = cpuReq.addr - `ADDR_FIXMAP;
	assign regSel = (cpuReq.addr == `ADDR_REG_BANK) ? neo_video_pkg::REG_BANK
		: neo_video_pkg::REG_SHADOW;

	// Address decode
	always_comb
	begin
		if (cpuReq.addr[15:8] == `ADDR_PALETTE >> 8)
			region = neo_video_pkg::REGION_PALETTE;
		else if ((cpuReq.addr >= `ADDR_FIXMAP) && (mapOffset < 16'(`MAP_COLS * `MAP_ROWS)))
			region = neo_video_pkg::REGION_FIXMAP;
		else if ((cpuReq.addr == `ADDR_REG_SHADOW) || (cpuReq.addr == `ADDR_REG_BANK))
			region = neo_video_pkg::REGION_REG;
		else
			region = neo_video_pkg::REGION_NONE;
	end

	// Palette port, CPU always sees the selected bank
	always_comb
	begin
		palWr.index = cpuReq.addr[7:0];
		palWr.bank  = palBank;
		palWr.data  = cpuReq.data;
		palWr.wr    = cpuReq.wr && (region == neo_video_pkg::REGION_PALETTE);
	end

	// Map port, index kept in range when not addressed
	always_comb
	begin
		mapWr.index = (region == neo_video_pkg::REGION_FIXMAP) ? mapOffset[10:0] : '0;
		mapWr.data  = cpuReq.data;
		mapWr.wr    = cpuReq.wr && (region == neo_video_pkg::REGION_FIXMAP);
	end

	always_ff @(posedge CLK_6MB)
	begin
		if (reset)
		begin
			shadow     <= 1'b0;
			palBank    <= 1'b0;
			prevRead   <= 1'b0;
			prevRegion <= neo_video_pkg::REGION_NONE;
			heldData   <= '0;
		end
		else
		begin
			if (cpuReq.wr && (region == neo_video_pkg::REGION_REG))
			begin
				if (regSel == neo_video_pkg::REG_BANK)
					palBank <= cpuReq.data[0];
				else
					shadow <= cpuReq.data[0];
			end
			prevRead   <= cpuReq.rd;
			prevRegion <= region;
			heldData   <= cpuDataOut;
		end
	end

	// Register value sampled with the strobe
	always_ff @(posedge CLK_6MB)
	begin
		regReadData <= {15'd0, (regSel == neo_video_pkg::REG_BANK) ? palBank : shadow};
	end

	always_comb
	begin
		case (prevRegion)
			neo_video_pkg::REGION_PALETTE: readMux = palReadData;
			neo_video_pkg::REGION_FIXMAP:  readMux = mapReadData;
			neo_video_pkg::REGION_REG:     readMux = regReadData;
			default:                       readMux = '0;
		endcase
	end

	// Fresh data the cycle after the strobe, held until the next read
	assign cpuDataOut = prevRead ? readMux : heldData;

endmodule

`default_nettype wire

// ==== src/fixLayer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_video_params.svh"

module fixLayer
(
	input  logic                     CLK_6MB,
	input  logic                     reset,
	input  neo_video_pkg::rasterPos_t pos,
	input  neo_video_pkg::mapWrite_t mapWr,
	input  logic [10:0]              cpuMapIndex,
	output logic [15:0]              mapReadData,
	output logic [7:0]               palIndex
);

	logic [15:0] mapRam [0:`MAP_COLS*`MAP_ROWS-1];
	logic [31:0] fixRom [0:`FIX_TILES*8-1];

	logic [10:0] videoMapIndex;
	logic [15:0] mapEntry;
	logic [2:0]  xLow1;
	logic [2:0]  yLow1;
	logic        active1;
	logic [4:0]  romAddr;
	logic [31:0] romRow;
	logic [3:0]  palNum2;
	logic [2:0]  xLow2;
	logic        active2;

	initial
	begin
		$readmemh("fix.hex", fixRom);
	end

	// Tile map, cleared at reset
	always_ff @(posedge CLK_6MB)
	begin
		if (reset)
		begin
			for (int i = 0; i < `MAP_COLS * `MAP_ROWS; i++)
				mapRam[i] <= '0;
		end
		else if (mapWr.wr)
		begin
			mapRam[mapWr.index] <= mapWr.data;
		end
	end

	// CPU readback port
	always_ff @(posedge CLK_6MB)
	begin
		mapReadData <= mapRam[cpuMapIndex];
	end

	// Row y/8, column x/8; blank area reads entry 0
	assign videoMapIndex = pos.active
		? 11'(pos.y[8:3] * `MAP_COLS + pos.x[8:3])
		: '0;

	// Stage one: map entry
	always_ff @(posedge CLK_6MB)
	begin
		mapEntry <= mapRam[videoMapIndex];
		xLow1    <= pos.x[2:0];
		yLow1    <= pos.y[2:0];
	end

	// Only the low code bits select a pattern
	assign romAddr = 5'((mapEntry[11:0] % `FIX_TILES) * 8 + yLow1);

	// Stage two: pattern row
	always_ff @(posedge CLK_6MB)
	begin
		romRow  <= fixRom[romAddr];
		palNum2 <= mapEntry[15:12];
		xLow2   <= xLow1;
	end

	always_ff @(posedge CLK_6MB)
	begin
		if (reset)
		begin
			active1 <= 1'b0;
			active2 <= 1'b0;
		end
		else
		begin
			active1 <= pos.active;
			active2 <= active1;
		end
	end

	// Leftmost pixel sits in the top nibble
	assign palIndex = active2 ? {palNum2, romRow[{~xLow2, 2'b00} +: 4]} : 8'd0;

endmodule

`default_nettype wire

// ==== src/paletteRam.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_video_params.svh"

module paletteRam
(
	input  logic                     CLK_6MB,
	input  neo_video_pkg::palWrite_t palWr,
	input  logic [7:0]               cpuIndex,
	input  logic                     palBank,
	input  logic [7:0]               palIndex,
	output logic [15:0]              cpuReadData,
	output logic [15:0]              color
);

	// Two banks back to back, bank is the top address bit
	logic [15:0] palMem [0:2*`PAL_ENTRIES-1];

	logic [8:0] writeAddr;
	logic [8:0] cpuAddr;
	logic [8:0] videoAddr;
	logic       transparent;

	assign writeAddr = {palWr.bank, palWr.index};
	assign cpuAddr   = {palBank, cpuIndex};

	// Color 0 of any palette shows the backdrop
	assign transparent = (palIndex[3:0] == 4'd0);
	assign videoAddr   = {palBank, transparent ? 8'(`BACKDROP_INDEX) : palIndex};

	always_ff @(posedge CLK_6MB)
	begin
		if (palWr.wr)
			palMem[writeAddr] <= palWr.data;
	end

	always_ff @(posedge CLK_6MB)
	begin
		cpuReadData <= palMem[cpuAddr];
	end

	always_ff @(posedge CLK_6MB)
	begin
		color <= palMem[videoAddr];
	end

endmodule

`default_nettype wire

// ==== src/colorOutput.sv ====
`timescale 1ns/1ps
`default_nettype none

module colorOutput
(
	input  logic        CLK_6MB,
	input  logic        reset,
	input  logic [15:0] color,
	input  logic        active,
	input  logic        nSync,
	input  logic        shadow,
	output logic [6:0]  videoR,
	output logic [6:0]  videoG,
	output logic [6:0]  videoB,
	output logic        videoSync
);

	logic dark;

	assign dark = color[15];

	// Per channel: shadow, nibble, low bit, dark
	always_ff @(posedge CLK_6MB)
	begin
		if (reset || !active)
		begin
			videoR <= '0;
			videoG <= '0;
			videoB <= '0;
		end
		else
		begin
			videoR <= {~shadow, color[11:8], color[14], ~dark};
			videoG <= {~shadow, color[7:4], color[13], ~dark};
			videoB <= {~shadow, color[3:0], color[12], ~dark};
		end
	end

	always_ff @(posedge CLK_6MB)
	begin
		if (reset)
			videoSync <= 1'b1;
		else
			videoSync <= nSync;
	end

endmodule

`default_nettype wire

// ==== src/neoVideo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_video_params.svh"

module neoVideo
(
	input  logic                   CLK_6MB,
	input  logic                   reset,
	input  neo_video_pkg::busReq_t cpuReq,
	output logic [15:0]            cpuDataOut,
	output logic [6:0]             videoR,
	output logic [6:0]             videoG,
	output logic [6:0]             videoB,
	output logic                   videoSync
);

	neo_video_pkg::rasterPos_t rasterPos;
	neo_video_pkg::rasterPos_t posPipe [`PIPE_DELAY-1];
	neo_video_pkg::palWrite_t  palWr;
	neo_video_pkg::mapWrite_t  mapWr;

	logic [15:0] palReadData;
	logic [15:0] mapReadData;
	logic [15:0] color;
	logic [7:0]  palIndex;
	logic        palBank;
	logic        shadow;

	videoTiming i_videoTiming
	(
		.CLK_6MB (CLK_6MB),
		.reset   (reset),
		.pos     (rasterPos)
	);

	cpuBusDecode i_cpuBusDecode
	(
		.CLK_6MB     (CLK_6MB),
		.reset       (reset),
		.cpuReq      (cpuReq),
		.palReadData (palReadData),
		.mapReadData (mapReadData),
		.palWr       (palWr),
		.mapWr       (mapWr),
		.cpuDataOut  (cpuDataOut),
		.palBank     (palBank),
		.shadow      (shadow)
	);

	fixLayer i_fixLayer
	(
		.CLK_6MB     (CLK_6MB),
		.reset       (reset),
		.pos         (rasterPos),
		.mapWr       (mapWr),
		.cpuMapIndex (mapWr.index),
		.mapReadData (mapReadData),
		.palIndex    (palIndex)
	);

	paletteRam i_paletteRam
	(
		.CLK_6MB     (CLK_6MB),
		.palWr       (palWr),
		.cpuIndex    (palWr.index),
		.palBank     (palBank),
		.palIndex    (palIndex),
		.cpuReadData (palReadData),
		.color       (color)
	);

	// Timing follows the color data through map, ROM and palette stages
	always_ff @(posedge CLK_6MB)
	begin
		if (reset)
		begin
			for (int i = 0; i < `PIPE_DELAY - 1; i++)
			begin
				posPipe[i]       <= '0;
				posPipe[i].nSync <= 1'b1;
			end
		end
		else
		begin
			posPipe[0] <= rasterPos;
			for (int i = 1; i < `PIPE_DELAY - 1; i++)
				posPipe[i] <= posPipe[i-1];
		end
	end

	colorOutput i_colorOutput
	(
		.CLK_6MB   (CLK_6MB),
		.reset     (reset),
		.color     (color),
		.active    (posPipe[`PIPE_DELAY-2].active),
		.nSync     (posPipe[`PIPE_DELAY-2].nSync),
		.shadow    (shadow),
		.videoR    (videoR),
		.videoG    (videoG),
		.videoB    (videoB),
		.videoSync (videoSync)
	);

endmodule

`default_nettype wire

// ==== tests/neoVideo_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_video_params.svh"

module neoVideo_sva
(
	input logic       CLK_6MB,
	input logic       reset,
	input logic       pixelActive,
	input logic       palWrite,
	input logic       mapWrite,
	input logic [6:0] videoR,
	input logic [6:0] videoG,
	input logic [6:0] videoB,
	input logic       videoSync
);

	// Inactive pixel at the color latch gives black on the next cycle
	property blankIsBlack;
		@(posedge CLK_6MB) disable iff (reset)
			!pixelActive |=> (videoR == 7'd0) && (videoG == 7'd0) && (videoB == 7'd0);
	endproperty

	// One decoded region per access
	property oneWriteTarget;
		@(posedge CLK_6MB) !(palWrite && mapWrite);
	endproperty

	property syncHighInReset;
		@(posedge CLK_6MB) reset |=> videoSync;
	endproperty

	blankCheck: assert property (blankIsBlack)
		else $error("RGB not black after an inactive pixel");

	writeCheck: assert property (oneWriteTarget)
		else $error("palette and tile map written in the same cycle");

	syncCheck: assert property (syncHighInReset)
		else $error("videoSync low during reset");

endmodule

bind neoVideo neoVideo_sva i_neoVideo_sva
(
	.CLK_6MB     (CLK_6MB),
	.reset       (reset),
	.pixelActive (posPipe[`PIPE_DELAY-2].active),
	.palWrite    (palWr.wr),
	.mapWrite    (mapWr.wr),
	.videoR      (videoR),
	.videoG      (videoG),
	.videoB      (videoB),
	.videoSync   (videoSync)
);

`default_nettype wire

// ==== tests/neoVideo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_video_params.svh"

module neoVideo_tb;

	localparam int CLK_PERIOD   = 100;
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int MAP_ENTRIES  = `MAP_COLS * `MAP_ROWS;
	localparam int N_RANDOM     = 64;
	// Bound on every CPU access outside the two checked frames
	localparam int TRAFFIC_CYCLES = 2 * (4 * `PAL_ENTRIES + 2 * MAP_ENTRIES + 8 * N_RANDOM + 64);
	localparam longint WATCHDOG_NS = longint'(4 * FRAME_CYCLES + TRAFFIC_CYCLES) * CLK_PERIOD;

	logic                   CLK_6MB;
	logic                   reset;
	neo_video_pkg::busReq_t cpuReq;
	logic [15:0]            cpuDataOut;
	logic [6:0]             videoR;
	logic [6:0]             videoG;
	logic [6:0]             videoB;
	logic                   videoSync;

	// Reference model state
	logic [15:0] palModel [0:1][0:`PAL_ENTRIES-1];
	logic [15:0] mapModel [0:MAP_ENTRIES-1];
	logic [31:0] romModel [0:`FIX_TILES*8-1];
	logic        shadowModel;
	logic        bankModel;

	logic [15:0] unmapped [0:4] = '{16'h0100, 16'h1460, 16'h2002, 16'h1FFF, 16'hFFFF};

	int seed;
	int cycleCount;
	int testsRun;
	int testsFailed;
	int checksFailed;

	neoVideo i_neoVideo
	(
		.CLK_6MB    (CLK_6MB),
		.reset      (reset),
		.cpuReq     (cpuReq),
		.cpuDataOut (cpuDataOut),
		.videoR     (videoR),
		.videoG     (videoG),
		.videoB     (videoB),
		.videoSync  (videoSync)
	);

	always #(CLK_PERIOD / 2) CLK_6MB = ~CLK_6MB;

	// All driving and sampling happens on the falling edge
	task automatic tick();
		@(negedge CLK_6MB);
		cycleCount++;
	endtask

	task automatic busWrite(input logic [15:0] addr, input logic [15:0] data);
		cpuReq.addr = addr;
		cpuReq.data = data;
		cpuReq.wr   = 1'b1;
		cpuReq.rd   = 1'b0;
		tick();
		cpuReq.wr = 1'b0;
	endtask

	task automatic busRead(input logic [15:0] addr, output logic [15:0] data);
		cpuReq.addr = addr;
		cpuReq.data = 16'd0;
		cpuReq.wr   = 1'b0;
		cpuReq.rd   = 1'b1;
		tick();
		data = cpuDataOut;
		cpuReq.rd = 1'b0;
	endtask

	task automatic writePalette(input logic [7:0] index, input logic [15:0] data);
		busWrite(`ADDR_PALETTE + {8'd0, index}, data);
		palModel[bankModel][index] = data;
	endtask

	task automatic writeMap(input logic [10:0] index, input logic [15:0] data);
		busWrite(`ADDR_FIXMAP + {5'd0, index}, data);
		mapModel[index] = data;
	endtask

	task automatic writeShadow(input logic value);
		busWrite(`ADDR_REG_SHADOW, {15'd0, value});
		shadowModel = value;
	endtask

	task automatic writeBank(input logic value);
		busWrite(`ADDR_REG_BANK, {15'd0, value});
		bankModel = value;
	endtask

	task automatic checkValue(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual, inout int errors);
		assert (actual === expected)
		else
		begin
			errors++;
			checksFailed++;
			$display("FAILED %s (%s): expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic endTest(input string testName, input int errors);
		testsRun++;
		if (errors == 0)
			$display("%-14s ok", testName);
		else
		begin
			testsFailed++;
			$display("%-14s %0d mismatches", testName, errors);
		end
	endtask

	task automatic checkIdle(input string testName, inout int errors);
		checkValue(testName, "rgb", 32'd0, 32'({videoR, videoG, videoB}), errors);
		checkValue(testName, "sync", 32'd1, 32'(videoSync), errors);
		checkValue(testName, "cpu data", 32'd0, 32'(cpuDataOut), errors);
	endtask

	// Channel bits from the top are inverted shadow, nibble, low bit and inverted dark
	function automatic logic [6:0] expandChannel(input logic [3:0] nibble, input logic lowBit,
		input logic dark);
		return {~shadowModel, nibble, lowBit, ~dark};
	endfunction

	function automatic logic [20:0] expectedRgb(input int x, input int y);
		logic [15:0] entry;
		logic [31:0] row;
		logic [3:0]  nibble;
		logic [7:0]  index;
		logic [15:0] word;
		int          tile;
		if ((x >= `H_VISIBLE) || (y >= `V_VISIBLE))
			return 21'd0;
		entry  = mapModel[(y / 8) * `MAP_COLS + x / 8];
		tile   = int'(entry[11:0]) % `FIX_TILES;
		row    = romModel[tile * 8 + y % 8];
		nibble = row[(7 - x % 8) * 4 +: 4];
		// Color 0 shows the backdrop entry
		index  = (nibble == 4'd0) ? 8'(`BACKDROP_INDEX) : {entry[15:12], nibble};
		word   = palModel[bankModel][index];
		return {expandChannel(word[11:8], word[14], word[15]),
			expandChannel(word[7:4], word[13], word[15]),
			expandChannel(word[3:0], word[12], word[15])};
	endfunction

	function automatic logic expectedSync(input int x, input int y);
		logic inH;
		logic inV;
		inH = (x >= `H_SYNC_START) && (x < `H_SYNC_END);
		inV = (y >= `V_SYNC_START) && (y < `V_SYNC_END);
		return !(inH || inV);
	endfunction

	// Output at cycle n shows the position counted at n minus the pipeline delay
	task automatic checkFrame(input string visName, input string blankName,
		output int visErrors, output int blankErrors);
		int n;
		int x;
		int y;
		string where;
		visErrors   = 0;
		blankErrors = 0;
		repeat (`PIPE_DELAY) tick();
		while (((cycleCount - `PIPE_DELAY) % FRAME_CYCLES) != 0)
			tick();
		for (int i = 0; i < FRAME_CYCLES; i++)
		begin
			n     = cycleCount - `PIPE_DELAY;
			x     = n % `H_TOTAL;
			y     = (n / `H_TOTAL) % `V_TOTAL;
			where = $sformatf("pixel %0d,%0d", x, y);
			if ((x < `H_VISIBLE) && (y < `V_VISIBLE))
				checkValue(visName, where, 32'(expectedRgb(x, y)),
					32'({videoR, videoG, videoB}), visErrors);
			else
				checkValue(blankName, where, 32'd0, 32'({videoR, videoG, videoB}), blankErrors);
			checkValue(blankName, {where, " sync"}, 32'(expectedSync(x, y)), 32'(videoSync),
				blankErrors);
			tick();
		end
	endtask

	initial
	begin
		int          errors;
		int          errors2;
		logic [31:0] r;
		logic [31:0] r2;
		logic [15:0] data;
		logic [10:0] mapIndex;

		CLK_6MB      = 1'b0;
		reset        = 1'b1;
		cpuReq       = '0;
		seed         = 32'h6910_de15;
		cycleCount   = 0;
		testsRun     = 0;
		testsFailed  = 0;
		checksFailed = 0;
		shadowModel  = 1'b0;
		bankModel    = 1'b0;
		$readmemh("fix.hex", romModel);

		// Reset state during reset and just after
		errors = 0;
		repeat (4)
		begin
			tick();
			checkIdle("reset_state", errors);
		end
		reset      = 1'b0;
		cycleCount = 0;
		repeat (`PIPE_DELAY)
		begin
			checkIdle("reset_state", errors);
			tick();
		end
		endTest("reset_state", errors);

		// Palette fill of both banks and random traffic with bank switching
		errors = 0;
		for (int b = 0; b < 2; b++)
		begin
			writeBank(b[0]);
			for (int i = 0; i < `PAL_ENTRIES; i++)
			begin
				r = $random(seed);
				writePalette(i[7:0], r[15:0]);
			end
		end
		for (int i = 0; i < N_RANDOM; i++)
		begin
			r  = $random(seed);
			r2 = $random(seed);
			writeBank(r[8]);
			writePalette(r[7:0], r[31:16]);
			writeBank(r2[8]);
			busRead(`ADDR_PALETTE + {8'd0, r2[7:0]}, data);
			checkValue("palette", $sformatf("bank %0d entry %0d", r2[8], r2[7:0]),
				32'(palModel[bankModel][r2[7:0]]), 32'(data), errors);
		end
		endTest("palette", errors);

		// Registers, tile map and unmapped reads
		errors = 0;
		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			writeShadow(r[0]);
			busRead(`ADDR_REG_SHADOW, data);
			checkValue("reg_map", "shadow", 32'(shadowModel), 32'(data), errors);
			writeBank(r[1]);
			busRead(`ADDR_REG_BANK, data);
			checkValue("reg_map", "bank", 32'(bankModel), 32'(data), errors);
		end
		for (int i = 0; i < N_RANDOM; i++)
		begin
			r        = $random(seed);
			mapIndex = 11'(int'(r[30:16]) % MAP_ENTRIES);
			writeMap(mapIndex, r[15:0]);
			busRead(`ADDR_FIXMAP + {5'd0, mapIndex}, data);
			checkValue("reg_map", $sformatf("map %0d", mapIndex), 32'(mapModel[mapIndex]),
				32'(data), errors);
		end
		for (int i = 0; i < 5 + 8; i++)
		begin
			r = $random(seed);
			busRead(i < 5 ? unmapped[i] : {2'b01, r[13:0]}, data);
			checkValue("reg_map", "unmapped", 32'd0, 32'(data), errors);
		end
		endTest("reg_map", errors);

		// Random map and one whole frame against the model
		writeShadow(1'b0);
		writeBank(1'b0);
		for (int i = 0; i < MAP_ENTRIES; i++)
		begin
			r = $random(seed);
			writeMap(i[10:0], r[15:0]);
		end
		checkFrame("frame", "blank_sync", errors, errors2);
		endTest("frame", errors);
		endTest("blank_sync", errors2);

		// Same map shadowed and through the other bank
		writeShadow(1'b1);
		writeBank(1'b1);
		checkFrame("shadow_bank", "shadow_bank", errors, errors2);
		endTest("shadow_bank", errors + errors2);

		$display("Tests: %0d run, %0d failed, %0d checks failed", testsRun, testsFailed,
			checksFailed);
		if (testsFailed == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fix.hex ====
// One pattern row per line, eight 4-bit pixels, leftmost pixel in the top nibble
// Rows 0-7 are tile 0, rows 8-15 tile 1, and so on
FFFFFFFF
F000000F
F012340F
F056780F
F09ABC0F
F0DEF10F
F000000F
FFFFFFFF
10101010
01010101
20202020
02020202
30303030
03030303
40404040
04040404
01234567
89ABCDEF
76543210
FEDCBA98
00112233
44556677
8899AABB
CCDDEEFF
E0000000
0D000000
00C00000
000B0000
0000A000
00000900
00000080
00000007

// ==== list.f ====
+incdir+include
src/neo_video_pkg.sv
src/videoTiming.sv
src/cpuBusDecode.sv
src/fixLayer.sv
src/paletteRam.sv
src/colorOutput.sv
src/neoVideo.sv
tests/neoVideo_sva.sv
tests/neoVideo_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := neoVideo_tb
FILELIST   := list.f
FLAGS      := --timing --assert
LINT_FLAGS := --lint-only
BUILD_DIR  := obj_dir
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run fails unless the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
